//--- verilog/fe_mem_settings.svh
`ifndef FE_MEM_SETTINGS_SVH
`define FE_MEM_SETTINGS_SVH

// Address split: vtag | page offset
`define FE_VADDR_WIDTH        16
`define FE_PAGE_OFFSET_WIDTH  8
`define FE_VTAG_WIDTH         8
`define FE_PTAG_WIDTH         8

// Translation buffer
`define FE_ITLB_ELS           4
`define FE_ITLB_IDX_WIDTH     2   // log2 of entry count

// Instruction cache, index sits in address bits 7:2
`define FE_ICACHE_SETS        64
`define FE_ICACHE_INDEX_WIDTH 6
`define FE_INSTR_OFFSET_WIDTH 2   // Byte offset inside one instruction

`define FE_INSTR_WIDTH        32

`endif

//--- verilog/fe_mem_pkg.sv
`include "fe_mem_settings.svh"

package fe_mem_pkg;

   typedef logic [`FE_VADDR_WIDTH-1:0]        vaddr_t;
   typedef logic [`FE_VTAG_WIDTH-1:0]         vtag_t;
   typedef logic [`FE_PTAG_WIDTH-1:0]         ptag_t;
   typedef logic [`FE_PAGE_OFFSET_WIDTH-1:0]  page_offset_t;
   typedef logic [`FE_ICACHE_INDEX_WIDTH-1:0] icache_index_t;
   typedef logic [`FE_INSTR_WIDTH-1:0]        instr_t;

   typedef struct packed {
      ptag_t        ptag;
      page_offset_t offset;
   } paddr_t;

   typedef enum logic [1:0] {
      fe_op_fetch,
      fe_op_tlb_fill,
      fe_op_tlb_fence
   } fe_op_e;

   typedef enum logic [1:0] {
      priv_u = 2'd0,
      priv_s = 2'd1,
      priv_m = 2'd3
   } priv_e;

   typedef struct packed {
      ptag_t ptag;
      logic  u;                            // User page
      logic  x;                            // Executable
   } tlb_entry_s;

   typedef struct packed {
      fe_op_e     op;
      vaddr_t     vaddr;                   // Fill takes its vtag from here too
      tlb_entry_s entry;
   } mem_cmd_s;

   typedef struct packed {
      logic   instr_access_fault;
      logic   instr_page_fault;
      logic   itlb_miss;
      logic   icache_miss;
      instr_t data;
   } mem_resp_s;

   typedef struct packed {
      paddr_t paddr;
      instr_t data;
   } icache_fill_s;

endpackage

//--- verilog/fe_itlb.sv
`include "fe_mem_settings.svh"

module fe_itlb (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   flush_i,
   input  logic                   translation_en_i,
   input  logic                   v_i,
   input  logic                   w_i,
   input  fe_mem_pkg::vtag_t      vtag_i,
   input  fe_mem_pkg::tlb_entry_s entry_i,
   output fe_mem_pkg::tlb_entry_s entry_o,
   output logic                   entry_v_o,
   output logic                   miss_o
);
   import fe_mem_pkg::*;

   logic [`FE_ITLB_ELS-1:0]       valid_r;
   logic [`FE_ITLB_ELS-1:0]       match;
   logic [`FE_ITLB_IDX_WIDTH-1:0] match_idx;
   logic [`FE_ITLB_IDX_WIDTH-1:0] victim_r;
   logic [`FE_ITLB_IDX_WIDTH-1:0] wr_idx;
   vtag_t                         vtag_mem [`FE_ITLB_ELS];
   tlb_entry_s                    entry_mem [`FE_ITLB_ELS];
   logic                          read_v_r;
   logic                          hit_r;
   vtag_t                         vtag_r;
   tlb_entry_s                    hit_entry_r;
   tlb_entry_s                    bypass_entry;

   // Fully associative search, shared by read and write
   always_comb begin
      match     = '0;
      match_idx = '0;
      for (int i = 0; i < `FE_ITLB_ELS; i++) begin
         match[i] = valid_r[i] & (vtag_mem[i] == vtag_i);
         if (match[i]) begin
            match_idx = i[`FE_ITLB_IDX_WIDTH-1:0];
         end
      end
   end

   assign wr_idx = (|match) ? match_idx : victim_r;   // Update in place on a hit

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r  <= '0;
         victim_r <= '0;
         read_v_r <= 1'b0;
         hit_r    <= 1'b0;
      end else begin
         read_v_r <= v_i & ~w_i;
         hit_r    <= |match;
         if (flush_i) begin
            valid_r <= '0;
         end else if (v_i & w_i) begin
            valid_r[wr_idx] <= 1'b1;
            if (~|match) begin
               victim_r <= victim_r + 1'b1;             // Round robin
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (v_i & w_i) begin
         vtag_mem[wr_idx]  <= vtag_i;
         entry_mem[wr_idx] <= entry_i;
      end
      if (v_i & ~w_i) begin
         vtag_r      <= vtag_i;
         hit_entry_r <= entry_mem[match_idx];
      end
   end

   // Identity mapping when translation is off
   assign bypass_entry = '{ptag: ptag_t'(vtag_r), u: 1'b0, x: 1'b1};

   assign entry_o   = translation_en_i ? hit_entry_r : bypass_entry;
   assign entry_v_o = read_v_r & (~translation_en_i | hit_r);
   assign miss_o    = read_v_r & translation_en_i & ~hit_r;

endmodule

//--- verilog/fe_icache.sv
`include "fe_mem_settings.svh"

module fe_icache (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  fe_mem_pkg::vaddr_t       vaddr_i,
   input  logic                     vaddr_v_i,
   input  fe_mem_pkg::ptag_t        ptag_i,
   input  fe_mem_pkg::icache_fill_s fill_i,
   input  logic                     fill_v_i,
   output logic                     fetch_v_o,
   output logic                     hit_o,
   output fe_mem_pkg::instr_t       data_o
);
   import fe_mem_pkg::*;

   // Index lies inside the page offset, so virtual and physical index agree
   icache_index_t                rd_idx;
   icache_index_t                fill_idx;

   ptag_t                        tag_mem  [`FE_ICACHE_SETS];
   instr_t                       data_mem [`FE_ICACHE_SETS];
   logic [`FE_ICACHE_SETS-1:0]   valid_r;

   logic                         fetch_v_r;
   logic                         line_v_r;
   ptag_t                        tag_rd_r;
   instr_t                       data_rd_r;

   assign rd_idx   = vaddr_i[`FE_INSTR_OFFSET_WIDTH +: `FE_ICACHE_INDEX_WIDTH];
   assign fill_idx = fill_i.paddr.offset[`FE_INSTR_OFFSET_WIDTH +: `FE_ICACHE_INDEX_WIDTH];

   // Stage 0, control part of the array read
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fetch_v_r <= 1'b0;
         line_v_r  <= 1'b0;
      end else begin
         fetch_v_r <= vaddr_v_i;
         if (vaddr_v_i) begin
            line_v_r <= valid_r[rd_idx];                   // Sees state before a same-cycle fill
         end
      end
   end

   // Stage 0, tag and data read
   always_ff @(posedge clk_i) begin
      if (vaddr_v_i) begin
         tag_rd_r  <= tag_mem[rd_idx];
         data_rd_r <= data_mem[rd_idx];
      end
   end

   // Line valid bits
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r <= '0;
      end else if (fill_v_i) begin
         valid_r[fill_idx] <= 1'b1;
      end
   end

   // Refill write port, one instruction per line
   always_ff @(posedge clk_i) begin
      if (fill_v_i) begin
         tag_mem[fill_idx]  <= fill_i.paddr.ptag;
         data_mem[fill_idx] <= fill_i.data;
      end
   end

   // Stage 1, physical tag compare
   assign fetch_v_o = fetch_v_r;
   assign hit_o     = fetch_v_r & line_v_r & (tag_rd_r == ptag_i);
   assign data_o    = data_rd_r;

endmodule

//--- verilog/fe_fetch_resp.sv
`include "fe_mem_settings.svh"

module fe_fetch_resp (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   fetch_v_i,
   input  logic                   poison_i,
   input  fe_mem_pkg::priv_e      priv_i,
   input  logic                   translation_en_i,
   input  fe_mem_pkg::tlb_entry_s entry_i,
   input  logic                   itlb_miss_i,
   input  logic                   cache_hit_i,
   input  fe_mem_pkg::instr_t     data_i,
   output fe_mem_pkg::mem_resp_s  resp_o,
   output logic                   resp_v_o
);
   import fe_mem_pkg::*;

   logic      io_region;
   logic      priv_fault;
   logic      access_fault;
   logic      page_fault;
   logic      fault;
   mem_resp_s resp_n;
   mem_resp_s resp_r;
   logic      resp_v_r;

   assign io_region    = entry_i.ptag[`FE_PTAG_WIDTH-1];  // Top tag bit marks I/O space
   assign priv_fault   = ((priv_i == priv_s) & entry_i.u) | ((priv_i == priv_u) & ~entry_i.u);
   assign access_fault = ~itlb_miss_i & io_region;
   assign page_fault   = ~itlb_miss_i & translation_en_i & (~entry_i.x | priv_fault);
   assign fault        = access_fault | page_fault;

   // A TLB miss overrides every other outcome
   always_comb begin
      resp_n.instr_access_fault = access_fault;
      resp_n.instr_page_fault   = page_fault;
      resp_n.itlb_miss          = itlb_miss_i;
      resp_n.icache_miss        = ~itlb_miss_i & ~fault & ~cache_hit_i;
      resp_n.data               = (~itlb_miss_i & ~fault & cache_hit_i) ? data_i : '0;
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         resp_v_r <= 1'b0;
      end else begin
         resp_v_r <= fetch_v_i & ~poison_i;               // Poison kills the response
      end
   end

   always_ff @(posedge clk_i) begin
      if (fetch_v_i) begin
         resp_r <= resp_n;
      end
   end

   assign resp_o   = resp_r;
   assign resp_v_o = resp_v_r;

endmodule

//--- verilog/fe_mem.sv
`include "fe_mem_settings.svh"

module fe_mem (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  fe_mem_pkg::mem_cmd_s     mem_cmd_i,
   input  logic                     mem_cmd_v_i,
   input  fe_mem_pkg::priv_e        mem_priv_i,
   input  logic                     mem_translation_en_i,
   input  logic                     mem_poison_i,
   input  fe_mem_pkg::icache_fill_s icache_fill_i,
   input  logic                     icache_fill_v_i,
   output fe_mem_pkg::mem_resp_s    mem_resp_o,
   output logic                     mem_resp_v_o
);
   import fe_mem_pkg::*;

   logic       fetch_v;
   logic       tlb_fill_v;
   logic       tlb_fence_v;
   vtag_t      cmd_vtag;
   tlb_entry_s itlb_entry;
   logic       itlb_entry_v;
   logic       itlb_miss;
   logic       icache_fetch_v;
   logic       icache_hit;
   instr_t     icache_data;

   // Every strobe is taken, so decode is purely combinational
   assign fetch_v     = mem_cmd_v_i & (mem_cmd_i.op == fe_op_fetch);
   assign tlb_fill_v  = mem_cmd_v_i & (mem_cmd_i.op == fe_op_tlb_fill);
   assign tlb_fence_v = mem_cmd_v_i & (mem_cmd_i.op == fe_op_tlb_fence);
   assign cmd_vtag    = mem_cmd_i.vaddr[`FE_VADDR_WIDTH-1 -: `FE_VTAG_WIDTH];

   fe_itlb itlb0 (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .flush_i          (tlb_fence_v),
      .translation_en_i (mem_translation_en_i),
      .v_i              (fetch_v | tlb_fill_v),
      .w_i              (tlb_fill_v),
      .vtag_i           (cmd_vtag),
      .entry_i          (mem_cmd_i.entry),
      .entry_o          (itlb_entry),
      .entry_v_o        (itlb_entry_v),
      .miss_o           (itlb_miss)
   );

   fe_icache icache0 (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .vaddr_i   (mem_cmd_i.vaddr),
      .vaddr_v_i (fetch_v),
      .ptag_i    (itlb_entry.ptag),
      .fill_i    (icache_fill_i),
      .fill_v_i  (icache_fill_v_i),
      .fetch_v_o (icache_fetch_v),
      .hit_o     (icache_hit),
      .data_o    (icache_data)
   );

   fe_fetch_resp resp0 (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .fetch_v_i        (icache_fetch_v),
      .poison_i         (mem_poison_i),
      .priv_i           (mem_priv_i),
      .translation_en_i (mem_translation_en_i),
      .entry_i          (itlb_entry),
      .itlb_miss_i      (itlb_miss),
      .cache_hit_i      (icache_hit & itlb_entry_v),  // Hit counts only with a valid ptag
      .data_i           (icache_data),
      .resp_o           (mem_resp_o),
      .resp_v_o         (mem_resp_v_o)
   );

endmodule

//--- verif/fe_mem_properties.sv
module fe_mem_properties (
   input logic                  clk_i,
   input logic                  reset_i,
   input fe_mem_pkg::mem_cmd_s  mem_cmd_i,
   input logic                  mem_cmd_v_i,
   input fe_mem_pkg::mem_resp_s mem_resp_o,
   input logic                  mem_resp_v_o
);
   import fe_mem_pkg::*;

   logic fetch_v;
   logic fault;

   assign fetch_v = mem_cmd_v_i && (mem_cmd_i.op == fe_op_fetch);
   assign fault   = mem_resp_o.instr_access_fault | mem_resp_o.instr_page_fault;

   resp_idle_after_reset: assert property (@(posedge clk_i) reset_i |=> !mem_resp_v_o)
      else $error("response valid in the cycle after reset");

   resp_needs_fetch: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_resp_v_o |-> $past(fetch_v, 2))
      else $error("response without a fetch two cycles earlier");

   miss_stands_alone: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_resp_v_o && mem_resp_o.itlb_miss |-> !mem_resp_o.icache_miss && !fault)
      else $error("itlb miss combined with another flag");

   fault_zero_data: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_resp_v_o && fault |-> mem_resp_o.data == '0)
      else $error("fault response carries data");

endmodule

bind fe_mem fe_mem_properties props0 (
   .clk_i        (clk_i),
   .reset_i      (reset_i),
   .mem_cmd_i    (mem_cmd_i),
   .mem_cmd_v_i  (mem_cmd_v_i),
   .mem_resp_o   (mem_resp_o),
   .mem_resp_v_o (mem_resp_v_o)
);

//--- verif/fe_mem_tb.sv
`include "fe_mem_settings.svh"

module fe_mem_tb;
   import fe_mem_pkg::*;

   logic         clk;
   logic         reset;
   mem_cmd_s     mem_cmd;
   logic         mem_cmd_v;
   priv_e        mem_priv;
   logic         mem_trans_en;
   logic         mem_poison;
   icache_fill_s icache_fill;
   logic         icache_fill_v;
   mem_resp_s    mem_resp;
   logic         mem_resp_v;
   logic [31:0]  lfsr;
   int           errors;
   int           checks;
   int           tests;
   logic         line_v [`FE_ICACHE_SETS];         // Cache contents as filled so far
   ptag_t        line_tag [`FE_ICACHE_SETS];
   instr_t       line_data [`FE_ICACHE_SETS];

   fe_mem dut0 (
      .clk_i                (clk),
      .reset_i              (reset),
      .mem_cmd_i            (mem_cmd),
      .mem_cmd_v_i          (mem_cmd_v),
      .mem_priv_i           (mem_priv),
      .mem_translation_en_i (mem_trans_en),
      .mem_poison_i         (mem_poison),
      .icache_fill_i        (icache_fill),
      .icache_fill_v_i      (icache_fill_v),
      .mem_resp_o           (mem_resp),
      .mem_resp_v_o         (mem_resp_v)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);   // Galois step
      end
      return v;
   endfunction

   function automatic mem_resp_s expected_resp(input vaddr_t va, input logic tlb_hit,
                                               input tlb_entry_s e);
      mem_resp_s     r;
      ptag_t         pt;
      icache_index_t idx;
      r   = '0;
      pt  = mem_trans_en ? e.ptag : va[`FE_VADDR_WIDTH-1 -: `FE_VTAG_WIDTH];
      idx = va[7:2];
      if (mem_trans_en && !tlb_hit) begin
         r.itlb_miss = 1'b1;
         return r;
      end
      r.instr_access_fault = pt[`FE_PTAG_WIDTH-1];   // I/O space
      r.instr_page_fault   = mem_trans_en && (!e.x || (mem_priv == priv_s && e.u)
                                              || (mem_priv == priv_u && !e.u));
      if (!r.instr_access_fault && !r.instr_page_fault) begin
         r.icache_miss = !(line_v[idx] && line_tag[idx] == pt);
         r.data        = r.icache_miss ? '0 : line_data[idx];
      end
      return r;
   endfunction

   task automatic compare_resp(input string name, input mem_resp_s exp, input mem_resp_s act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic expect_valid(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         if (exp) begin
            $display("%s: no response arrived within the timeout", name);
         end else begin
            $display("%s: a response arrived although none was expected", name);
         end
      end
   endtask

   task automatic set_mode(input logic en, input priv_e p);
      @(posedge clk);
      #1;
      mem_trans_en = en;
      mem_priv     = p;
   endtask

   task automatic send_cmd(input fe_op_e op, input vaddr_t va, input tlb_entry_s e);
      @(posedge clk);
      #1;
      mem_cmd   = '{op: op, vaddr: va, entry: e};
      mem_cmd_v = 1'b1;
      @(posedge clk);
      #1;
      mem_cmd_v = 1'b0;
   endtask

   task automatic fill_line(input paddr_t pa, input instr_t d);
      icache_index_t idx;
      idx = pa.offset[7:2];
      @(posedge clk);
      #1;
      icache_fill   = '{paddr: pa, data: d};
      icache_fill_v = 1'b1;
      @(posedge clk);
      #1;
      icache_fill_v  = 1'b0;
      line_v[idx]    = 1'b1;
      line_tag[idx]  = pa.ptag;
      line_data[idx] = d;
   endtask

   task automatic issue_fetch(input vaddr_t va, input logic poison, output logic got,
                              output mem_resp_s resp);
      int n;
      send_cmd(fe_op_fetch, va, '0);
      mem_poison = poison;                          // Cycle after the fetch
      @(posedge clk);
      #1;
      mem_poison = 1'b0;
      got = 1'b0;
      n   = 0;
      while (!got && n < 10) begin
         @(negedge clk);
         n++;
         if (mem_resp_v) begin
            got  = 1'b1;
            resp = mem_resp;
         end
      end
   endtask

   task automatic fetch_and_compare(input string name, input vaddr_t va, input logic tlb_hit,
                                    input tlb_entry_s e);
      mem_resp_s exp;
      mem_resp_s act;
      logic      got;
      exp = expected_resp(va, tlb_hit, e);
      issue_fetch(va, 1'b0, got, act);
      expect_valid(name, 1'b1, got);
      if (got) begin
         compare_resp(name, exp, act);
      end
   endtask

   // Map a fresh page, fill one of its lines, then fetch it
   task automatic map_and_fetch(input string name, input priv_e p, input logic u,
                                input logic x, input logic io);
      tlb_entry_s e;
      vaddr_t     va;
      e  = '{ptag: {io, 7'(rand_bits(7))}, u: u, x: x};
      va = {8'(rand_bits(8)), 6'(rand_bits(6)), 2'b00};
      set_mode(1'b1, p);
      send_cmd(fe_op_tlb_fill, va, e);
      fill_line({e.ptag, va[7:0]}, rand_bits(32));
      fetch_and_compare(name, va, 1'b1, e);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests++;
      if (errors == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic bypass_fetch();
      vaddr_t va;
      int     e0;
      e0 = errors;
      va = {1'b0, 7'(rand_bits(7)), 6'(rand_bits(6)), 2'b00};
      set_mode(1'b0, priv_m);
      fetch_and_compare("bypass_cold", va, 1'b0, '0);
      fill_line(va, rand_bits(32));                 // Physical address equals virtual
      fetch_and_compare("bypass_warm", va, 1'b0, '0);
      report_test("bypass", e0);
   endtask

   task automatic translation();
      vaddr_t va;
      int     e0;
      e0 = errors;
      va = {8'(rand_bits(8)), 6'(rand_bits(6)), 2'b00};
      set_mode(1'b1, priv_m);
      fetch_and_compare("xlate_miss", va, 1'b0, '0);
      map_and_fetch("xlate_hit", priv_m, 1'b0, 1'b1, 1'b0);
      report_test("translation", e0);
   endtask

   task automatic permissions();
      int e0;
      e0 = errors;
      map_and_fetch("perm_no_exec", priv_m, 1'b0, 1'b0, 1'b0);
      map_and_fetch("perm_s_user", priv_s, 1'b1, 1'b1, 1'b0);
      map_and_fetch("perm_u_super", priv_u, 1'b0, 1'b1, 1'b0);
      map_and_fetch("perm_u_user", priv_u, 1'b1, 1'b1, 1'b0);
      report_test("permissions", e0);
   endtask

   task automatic memory_attributes();
      int e0;
      e0 = errors;
      map_and_fetch("pma_io", priv_m, 1'b0, 1'b1, 1'b1);
      report_test("memory_attributes", e0);
   endtask

   task automatic fence_and_evict();
      vaddr_t     va [5];
      tlb_entry_s e [5];
      int         e0;
      e0 = errors;
      set_mode(1'b1, priv_m);
      for (int i = 0; i < 5; i++) begin
         va[i] = {5'(rand_bits(5)), 3'(i), 6'(rand_bits(6)), 2'b00};   // Distinct vtags
         e[i]  = '{ptag: {1'b0, 7'(rand_bits(7))}, u: 1'b0, x: 1'b1};
         fill_line({e[i].ptag, va[i][7:0]}, rand_bits(32));
      end
      send_cmd(fe_op_tlb_fill, va[0], e[0]);
      fetch_and_compare("fence_before", va[0], 1'b1, e[0]);
      send_cmd(fe_op_tlb_fence, '0, '0);
      fetch_and_compare("fence_after", va[0], 1'b0, e[0]);
      for (int i = 0; i < 5; i++) begin
         send_cmd(fe_op_tlb_fill, va[i], e[i]);
      end
      fetch_and_compare("evict_oldest", va[0], 1'b0, e[0]);
      fetch_and_compare("evict_newest", va[4], 1'b1, e[4]);
      report_test("fence", e0);
   endtask

   task automatic poison_and_pipeline();
      vaddr_t    va0;
      vaddr_t    va1;
      mem_resp_s exp0;
      mem_resp_s exp1;
      mem_resp_s r0;
      mem_resp_s r1;
      logic      got0;
      logic      got1;
      int        n;
      int        e0;
      e0  = errors;
      va0 = {1'b0, 7'(rand_bits(7)), 6'(rand_bits(6)), 2'b00};
      va1 = va0 ^ 16'h0004;                         // Neighbouring line
      set_mode(1'b0, priv_m);
      fill_line(va0, rand_bits(32));
      fill_line(va1, rand_bits(32));
      exp0 = expected_resp(va0, 1'b0, '0);
      exp1 = expected_resp(va1, 1'b0, '0);
      @(posedge clk);
      #1;
      mem_cmd   = '{op: fe_op_fetch, vaddr: va0, entry: '0};
      mem_cmd_v = 1'b1;
      @(posedge clk);
      #1;
      mem_cmd.vaddr = va1;
      @(posedge clk);
      #1;
      mem_cmd_v = 1'b0;
      got0 = 1'b0;
      n    = 0;
      while (!got0 && n < 10) begin
         @(negedge clk);
         n++;
         got0 = mem_resp_v;
         r0   = mem_resp;
      end
      @(negedge clk);
      got1 = mem_resp_v;                            // Must follow in the next cycle
      r1   = mem_resp;
      expect_valid("pipe_first", 1'b1, got0);
      expect_valid("pipe_second", 1'b1, got1);
      if (got0 && got1) begin
         compare_resp("pipe_first", exp0, r0);
         compare_resp("pipe_second", exp1, r1);
      end
      issue_fetch(va0, 1'b1, got0, r0);
      expect_valid("poison", 1'b0, got0);
      fetch_and_compare("after_poison", va1, 1'b0, '0);
      report_test("poison_pipeline", e0);
   endtask

   initial begin
      lfsr          = 32'd73099;
      errors        = 0;
      checks        = 0;
      tests         = 0;
      reset         = 1'b1;
      mem_cmd       = '0;
      mem_cmd_v     = 1'b0;
      mem_priv      = priv_m;
      mem_trans_en  = 1'b0;
      mem_poison    = 1'b0;
      icache_fill   = '0;
      icache_fill_v = 1'b0;
      for (int i = 0; i < `FE_ICACHE_SETS; i++) begin
         line_v[i] = 1'b0;
      end
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
      bypass_fetch();
      translation();
      permissions();
      memory_attributes();
      fence_and_evict();
      poison_and_pipeline();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- list.f
+incdir+verilog
verilog/fe_mem_pkg.sv
verilog/fe_itlb.sv
verilog/fe_icache.sv
verilog/fe_fetch_resp.sv
verilog/fe_mem.sv
verif/fe_mem_properties.sv
verif/fe_mem_tb.sv
